// File: Bender.yml
package:
  name: conv_addr_gen

sources:
  - files:
      - source/conv_addr_pkg.sv
      - source/conv_cfg_capture.sv
      - source/conv_window_seq.sv
      - source/conv_rows.sv
      - source/conv_pixels.sv
      - source/conv_tap_out.sv
      - source/conv_addr_gen.sv
  - target: test
    files:
      - bench/conv_tap_checker.sv
      - bench/tb_conv_addr_gen.sv

// File: bench/conv_addr_vectors.txt
# J k s p in_h in_w            (hex, one job)
# T row col pad addr last      (hex, expected taps of that job in order)
J 2 1 0 2 3
T 0 0 0 0 0
T 0 1 0 1 0
T 1 0 0 3 0
T 1 1 0 4 0
T 0 1 0 1 0
T 0 2 0 2 0
T 1 1 0 4 0
T 1 2 0 5 1
J 2 1 1 1 1
T ffff ffff 1 0 0
T ffff 0 1 0 0
T 0 ffff 1 0 0
T 0 0 0 0 0
T ffff 0 1 0 0
T ffff ffff 1 0 0
T 0 0 0 0 0
T 0 ffff 1 0 0
T 0 ffff 1 0 0
T 0 0 0 0 0
T ffff ffff 1 0 0
T ffff 0 1 0 0
T 0 0 0 0 0
T 0 ffff 1 0 0
T ffff 0 1 0 0
T ffff ffff 1 0 1
J 1 2 0 3 4
T 0 0 0 0 0
T 0 2 0 2 0
T 2 0 0 8 0
T 2 2 0 a 1
J 2 1 0 2 3
T 0 0 0 0 0
T 0 1 0 1 0
T 1 0 0 3 0
T 1 1 0 4 0
T 0 1 0 1 0
T 0 2 0 2 0
T 1 1 0 4 0
T 1 2 0 5 1

// File: bench/conv_tap_checker.sv
`default_nettype none

module conv_tap_checker #(
    parameter int unsigned ADDR_W = 20
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     tap_valid,
    input  conv_addr_pkg::conv_tap_t tap,
    input  logic [ADDR_W-1:0]        addr,
    input  logic                     busy,
    input  logic                     done
);
    import conv_addr_pkg::*;

    // expected taps, all jobs back to back
    coord_t            exp_row[$];
    coord_t            exp_col[$];
    coord_t            exp_ky[$];
    coord_t            exp_kx[$];
    logic              exp_pad[$];
    logic [ADDR_W-1:0] exp_addr[$];
    logic              exp_last[$];

    int unsigned error_count = 0;
    int unsigned seen_count  = 0;
    // expected last flag of the current beat
    logic        last_exp;
    // done belongs on the beat after an expected last tap
    logic        done_due;

    ////////////////////////////////////////
    // helpers called from the testbench
    ////////////////////////////////////////

    task automatic push_tap(input coord_t row, input coord_t col, input coord_t ky,
                            input coord_t kx, input logic pad,
                            input logic [ADDR_W-1:0] a, input logic last);
        exp_row.push_back(row);
        exp_col.push_back(col);
        exp_ky.push_back(ky);
        exp_kx.push_back(kx);
        exp_pad.push_back(pad);
        exp_addr.push_back(a);
        exp_last.push_back(last);
    endtask

    task automatic note_failure(input string what);
        $display("%0t: %s", $time, what);
        error_count++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    ////////////////////////////////////////
    // beat compare, sampled mid cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (reset) begin
            done_due = 1'b0;
        end else begin
            compare_field("done", 32'(done_due), 32'(done));
            done_due = 1'b0;
            if (tap_valid) begin
                if (exp_row.size() == 0) begin
                    note_failure("extra tap seen after all expected taps were used up");
                end else begin
                    compare_field("tap.row", exp_row.pop_front(), tap.row);
                    compare_field("tap.col", exp_col.pop_front(), tap.col);
                    compare_field("tap.ky", exp_ky.pop_front(), tap.ky);
                    compare_field("tap.kx", exp_kx.pop_front(), tap.kx);
                    compare_field("tap.pad", exp_pad.pop_front(), tap.pad);
                    compare_field("addr", exp_addr.pop_front(), addr);
                    last_exp = exp_last.pop_front();
                    compare_field("tap.last", 32'(last_exp), 32'(tap.last));
                    done_due = last_exp;
                    seen_count++;
                end
                // taps only come out inside a job
                if (!busy) begin
                    note_failure("tap_valid was high while busy was low");
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_conv_addr_gen.sv
`default_nettype none

module tb_conv_addr_gen;
    import conv_addr_pkg::*;

    localparam int unsigned ADDR_W     = 20;
    localparam int unsigned JOB_LIMIT  = 2000;

    logic              clk;
    logic              reset;
    logic              start;
    conv_job_t         job;
    logic              en;
    logic              tap_valid;
    conv_tap_t         tap;
    logic [ADDR_W-1:0] addr;
    logic              busy;
    logic              done;

    // jobs and running tap totals from the vectors file
    conv_job_t   jobs[$];
    int unsigned tap_total[$];

    conv_addr_gen #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .job       (job),
        .en        (en),
        .tap_valid (tap_valid),
        .tap       (tap),
        .addr      (addr),
        .busy      (busy),
        .done      (done)
    );

    conv_tap_checker #(
        .ADDR_W (ADDR_W)
    ) chk (
        .clk       (clk),
        .reset     (reset),
        .tap_valid (tap_valid),
        .tap       (tap),
        .addr      (addr),
        .busy      (busy),
        .done      (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // vectors file
    ////////////////////////////////////////

    task automatic load_vectors();
        int          fd;
        string       line;
        int unsigned f0, f1, f2, f3, f4;
        int unsigned total;
        // kernel size and tap index within the current job
        int unsigned k_cur;
        int unsigned idx;
        total = 0;
        k_cur = 1;
        idx   = 0;
        fd = $fopen("bench/conv_addr_vectors.txt", "r");
        if (fd == 0) begin
            chk.note_failure("could not open the vectors file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] == "J") begin
                    void'($sscanf(line, "J %h %h %h %h %h", f0, f1, f2, f3, f4));
                    jobs.push_back('{k: kparam_t'(f0), s: kparam_t'(f1), p: kparam_t'(f2),
                                     in_h: coord_t'(f3), in_w: coord_t'(f4)});
                    tap_total.push_back(total);
                    k_cur = f0;
                    idx   = 0;
                end else if (line.len() > 0 && line[0] == "T") begin
                    void'($sscanf(line, "T %h %h %h %h %h", f0, f1, f2, f3, f4));
                    // kernel column runs fastest, then kernel row
                    chk.push_tap(coord_t'(f0), coord_t'(f1), coord_t'((idx / k_cur) % k_cur),
                                 coord_t'(idx % k_cur), f2[0], ADDR_W'(f3), f4[0]);
                    idx++;
                    total++;
                    tap_total[tap_total.size()-1] = total;
                end
            end
            $fclose(fd);
        end
    endtask

    // start pulse on the falling edge
    task automatic pulse_start(input conv_job_t j);
        @(negedge clk);
        job   = j;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int unsigned cycles;
        // remaining cycles of a long en stall
        int unsigned low_run;
        void'($urandom(32'hf72c50eb));
        reset = 1'b1;
        start = 1'b0;
        job   = '0;
        en    = 1'b0;
        low_run = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // idle after reset
        chk.compare_field("tap_valid", 0, tap_valid);
        chk.compare_field("busy", 0, busy);
        chk.compare_field("done", 0, done);
        load_vectors();
        foreach (jobs[i]) begin
            pulse_start(jobs[i]);
            chk.compare_field("busy", 1, busy);
            // start while busy must be dropped
            pulse_start('{k: 4'd1, s: 4'd1, p: 4'd0, in_h: 16'd9, in_w: 16'd9});
            cycles = 0;
            while (!done && cycles < JOB_LIMIT) begin
                @(negedge clk);
                if (low_run > 0) begin
                    en = 1'b0;
                    low_run--;
                end else if (($urandom % 32) == 0) begin
                    // occasional long stall
                    en      = 1'b0;
                    low_run = 4 + ($urandom % 12);
                end else begin
                    en = ($urandom % 4) != 0;
                end
                cycles++;
            end
            if (!done) begin
                chk.note_failure("timeout while waiting for done");
            end else if (chk.seen_count != tap_total[i]) begin
                chk.note_failure("taps missing when done arrived");
            end
            @(negedge clk);
            chk.compare_field("done", 0, done);
            chk.compare_field("busy", 0, busy);
        end
        en = 1'b0;
        repeat (5) @(negedge clk);
        $display("errors: %0d", chk.error_count);
        if (chk.error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: conv_addr_gen.f
source/conv_addr_pkg.sv
source/conv_cfg_capture.sv
source/conv_window_seq.sv
source/conv_rows.sv
source/conv_pixels.sv
source/conv_tap_out.sv
source/conv_addr_gen.sv
bench/conv_tap_checker.sv
bench/tb_conv_addr_gen.sv

// File: source/conv_addr_gen.sv
`default_nettype none

module conv_addr_gen #(
    parameter int unsigned ADDR_W = 20
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  conv_addr_pkg::conv_job_t job,
    input  logic                     en,
    output logic                     tap_valid,
    output conv_addr_pkg::conv_tap_t tap,
    output logic [ADDR_W-1:0]        addr,
    output logic                     busy,
    output logic                     done
);
    import conv_addr_pkg::*;

    conv_geom_t geom;
    logic       go;
    logic       step;
    logic       last;
    coord_t     iy_start;
    coord_t     ix_start;
    // loop wraps, innermost first
    logic       conv_pixels_add_end;
    logic       conv_rows_add_end;
    coord_t     row_y;
    coord_t     col_x;
    coord_t     ky;
    coord_t     kx;
    conv_tap_t  tap_in;

    ////////////////////////////////////////
    // job intake and window walk
    ////////////////////////////////////////

    conv_cfg_capture u_cfg (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .job   (job),
        .geom  (geom),
        .go    (go),
        .busy  (busy),
        .done  (done)
    );

    conv_window_seq u_window (
        .clk               (clk),
        .reset             (reset),
        .geom              (geom),
        .go                (go),
        .en                (en),
        .conv_rows_add_end (conv_rows_add_end),
        .step              (step),
        .iy_start          (iy_start),
        .ix_start          (ix_start),
        .last              (last)
    );

    ////////////////////////////////////////
    // kernel loops
    ////////////////////////////////////////

    conv_rows u_rows (
        .clk                 (clk),
        .reset               (reset),
        .step                (step),
        .conv_pixels_add_end (conv_pixels_add_end),
        .k                   (geom.k),
        .p                   (geom.p),
        .iy_start            (iy_start),
        .in_h                (geom.in_h),
        .row_y               (row_y),
        .idx_in_k            (ky),
        .conv_rows_add_end   (conv_rows_add_end)
    );

    conv_pixels u_pixels (
        .clk                 (clk),
        .reset               (reset),
        .step                (step),
        .k                   (geom.k),
        .p                   (geom.p),
        .ix_start            (ix_start),
        .in_w                (geom.in_w),
        .col_x               (col_x),
        .idx_in_k            (kx),
        .conv_pixels_add_end (conv_pixels_add_end)
    );

    // pad flag is filled in on the output side
    assign tap_in = '{row: row_y, col: col_x, ky: ky, kx: kx, pad: 1'b0, last: last};

    conv_tap_out #(
        .ADDR_W (ADDR_W)
    ) u_tap_out (
        .clk       (clk),
        .reset     (reset),
        .tap_in    (tap_in),
        .step      (step),
        .in_w      (geom.in_w),
        .tap_valid (tap_valid),
        .tap       (tap),
        .addr      (addr),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: source/conv_addr_pkg.sv
`default_nettype none

package conv_addr_pkg;

    ////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////

    // heights, widths, positions, mapped rows and columns
    typedef logic [15:0] coord_t;

    // kernel size, stride or padding
    typedef logic [3:0] kparam_t;

    // row or column that falls into the zero border
    localparam coord_t PAD_COORD = 16'hffff;

    ////////////////////////////////////////
    // job and geometry
    ////////////////////////////////////////

    // job as handed in from outside
    typedef struct packed {
        kparam_t k;
        kparam_t s;
        kparam_t p;
        coord_t  in_h;
        coord_t  in_w;
    } conv_job_t;

    // latched job plus derived output size
    typedef struct packed {
        kparam_t k;
        kparam_t s;
        kparam_t p;
        coord_t  in_h;
        coord_t  in_w;
        coord_t  out_h;
        coord_t  out_w;
    } conv_geom_t;

    ////////////////////////////////////////
    // one kernel tap
    ////////////////////////////////////////

    typedef struct packed {
        coord_t row;
        coord_t col;
        coord_t ky;
        coord_t kx;
        logic   pad;
        logic   last;
    } conv_tap_t;

endpackage

`default_nettype wire

// File: source/conv_cfg_capture.sv
`default_nettype none

module conv_cfg_capture (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  conv_addr_pkg::conv_job_t  job,
    output conv_addr_pkg::conv_geom_t geom,
    output logic                      go,
    output logic                      busy,
    input  logic                      done
);
    import conv_addr_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV,
        ST_RUN
    } state_t;

    state_t state;

    // padded extent minus k, one per axis
    logic [16:0] num_h;
    logic [16:0] num_w;
    // running remainders and quotients
    logic [16:0] rem_h;
    logic [16:0] rem_w;
    coord_t      quo_h;
    coord_t      quo_w;
    logic [16:0] s_ext;
    logic        h_more;
    logic        w_more;

    // k never exceeds the padded extent, so no underflow here
    assign num_h = 17'(job.in_h) + 17'({job.p, 1'b0}) - 17'(job.k);
    assign num_w = 17'(job.in_w) + 17'({job.p, 1'b0}) - 17'(job.k);

    assign s_ext  = 17'(geom.s);
    assign h_more = (rem_h >= s_ext);
    assign w_more = (rem_w >= s_ext);
    assign busy   = (state != ST_IDLE);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            go    <= 1'b0;
        end else begin
            go <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // a start while busy never reaches here
                    if (start) begin
                        state <= ST_DIV;
                    end
                end
                ST_DIV: begin
                    // both axes finished subtracting
                    if (!h_more && !w_more) begin
                        go    <= 1'b1;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // job latch and division
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            geom.k    <= job.k;
            geom.s    <= job.s;
            geom.p    <= job.p;
            geom.in_h <= job.in_h;
            geom.in_w <= job.in_w;
            rem_h     <= num_h;
            rem_w     <= num_w;
            quo_h     <= '0;
            quo_w     <= '0;
        end else if (state == ST_DIV) begin
            // one subtraction of s per axis and cycle
            if (h_more) begin
                rem_h <= rem_h - s_ext;
                quo_h <= quo_h + 16'd1;
            end
            if (w_more) begin
                rem_w <= rem_w - s_ext;
                quo_w <= quo_w + 16'd1;
            end
            // final quotient lands together with go
            geom.out_h <= quo_h + 16'd1;
            geom.out_w <= quo_w + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/conv_pixels.sv
`default_nettype none

module conv_pixels (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   step,
    input  conv_addr_pkg::kparam_t k,
    input  conv_addr_pkg::kparam_t p,
    input  conv_addr_pkg::coord_t  ix_start,
    input  conv_addr_pkg::coord_t  in_w,
    output conv_addr_pkg::coord_t  col_x,
    output conv_addr_pkg::coord_t  idx_in_k,
    output logic                   conv_pixels_add_end
);
    import conv_addr_pkg::*;

    coord_t      kx;
    coord_t      k_ext;
    coord_t      p_ext;
    // padded column under the current tap
    coord_t      kx_plus_ix;
    logic [16:0] hi_bound;
    logic        kx_wrap;

    assign k_ext = coord_t'(k);
    assign p_ext = coord_t'(p);

    // innermost loop, one count per tap
    assign kx_wrap = step && (kx + 16'd1 == k_ext);

    always_ff @(posedge clk) begin
        if (reset) begin
            kx <= '0;
        end else if (step) begin
            kx <= kx_wrap ? '0 : kx + 16'd1;
        end
    end

    ////////////////////////////////////////
    // padded column to input column
    ////////////////////////////////////////

    assign kx_plus_ix = kx + ix_start;
    // first padded column past the map
    assign hi_bound   = 17'(p_ext) + 17'(in_w);

    assign col_x = ((kx_plus_ix < p_ext) || (17'(kx_plus_ix) >= hi_bound)) ?
                   PAD_COORD : (kx_plus_ix - p_ext);

    assign conv_pixels_add_end = kx_wrap;
    assign idx_in_k            = kx;

endmodule

`default_nettype wire

// File: source/conv_rows.sv
`default_nettype none

module conv_rows (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   step,
    input  logic                   conv_pixels_add_end,
    input  conv_addr_pkg::kparam_t k,
    input  conv_addr_pkg::kparam_t p,
    input  conv_addr_pkg::coord_t  iy_start,
    input  conv_addr_pkg::coord_t  in_h,
    output conv_addr_pkg::coord_t  row_y,
    output conv_addr_pkg::coord_t  idx_in_k,
    output logic                   conv_rows_add_end
);
    import conv_addr_pkg::*;

    coord_t      ky;
    coord_t      k_ext;
    coord_t      p_ext;
    // padded row under the current tap
    coord_t      ky_plus_iy;
    logic [16:0] hi_bound;
    logic        ky_adv;
    logic        ky_wrap;

    assign k_ext = coord_t'(k);
    assign p_ext = coord_t'(p);

    // moves only when the column loop wraps
    assign ky_adv  = conv_pixels_add_end;
    assign ky_wrap = ky_adv && (ky + 16'd1 == k_ext);

    always_ff @(posedge clk) begin
        if (reset) begin
            ky <= '0;
        end else if (ky_adv) begin
            ky <= ky_wrap ? '0 : ky + 16'd1;
        end
    end

    ////////////////////////////////////////
    // padded row to input row
    ////////////////////////////////////////

    assign ky_plus_iy = ky + iy_start;
    // first padded row past the map
    assign hi_bound   = 17'(p_ext) + 17'(in_h);

    assign row_y = ((ky_plus_iy < p_ext) || (17'(ky_plus_iy) >= hi_bound)) ?
                   PAD_COORD : (ky_plus_iy - p_ext);

    assign conv_rows_add_end = ky_wrap;
    assign idx_in_k          = ky;

endmodule

`default_nettype wire

// File: source/conv_tap_out.sv
`default_nettype none

module conv_tap_out #(
    parameter int unsigned ADDR_W = 20
) (
    input  logic                     clk,
    input  logic                     reset,
    input  conv_addr_pkg::conv_tap_t tap_in,
    input  logic                     step,
    input  conv_addr_pkg::coord_t    in_w,
    output logic                     tap_valid,
    output conv_addr_pkg::conv_tap_t tap,
    output logic [ADDR_W-1:0]        addr,
    output logic                     done
);
    import conv_addr_pkg::*;

    logic              pad;
    // row-major offset, full product width
    logic [31:0]       lin;
    conv_tap_t         tap_next;
    logic [ADDR_W-1:0] addr_next;

    // either axis in the border pads the tap
    assign pad = (tap_in.row == PAD_COORD) || (tap_in.col == PAD_COORD);

    assign lin = 32'(tap_in.row) * 32'(in_w) + 32'(tap_in.col);

    always_comb begin
        tap_next     = tap_in;
        tap_next.pad = pad;
    end

    // pad taps read nothing, address forced to zero
    assign addr_next = pad ? '0 : ADDR_W'(lin);

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            tap_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            tap_valid <= step;
            // one edge after the final tap
            done      <= tap_valid && tap.last;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            tap  <= tap_next;
            addr <= addr_next;
        end
    end

endmodule

`default_nettype wire

// File: source/conv_window_seq.sv
`default_nettype none

module conv_window_seq (
    input  logic                      clk,
    input  logic                      reset,
    input  conv_addr_pkg::conv_geom_t geom,
    input  logic                      go,
    input  logic                      en,
    input  logic                      conv_rows_add_end,
    output logic                      step,
    output conv_addr_pkg::coord_t     iy_start,
    output conv_addr_pkg::coord_t     ix_start,
    output logic                      last
);
    import conv_addr_pkg::*;

    // walk in progress
    logic   active;
    // output window position
    coord_t oy;
    coord_t ox;
    logic   ox_wrap;
    logic   oy_wrap;
    coord_t s_ext;

    assign s_ext   = coord_t'(geom.s);
    assign ox_wrap = (ox + 16'd1 == geom.out_w);
    assign oy_wrap = (oy + 16'd1 == geom.out_h);

    // one tap per enabled active cycle
    assign step = active && en;

    // kernel loops end in the bottom right window
    assign last = conv_rows_add_end && ox_wrap && oy_wrap;

    ////////////////////////////////////////
    // window walk
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            oy       <= '0;
            ox       <= '0;
            iy_start <= '0;
            ix_start <= '0;
        end else if (go) begin
            active   <= 1'b1;
            oy       <= '0;
            ox       <= '0;
            iy_start <= '0;
            ix_start <= '0;
        end else if (conv_rows_add_end) begin
            if (ox_wrap) begin
                ox       <= '0;
                ix_start <= '0;
                if (oy_wrap) begin
                    // final tap just went out
                    active <= 1'b0;
                end else begin
                    oy       <= oy + 16'd1;
                    // origin advances by stride, no multiply
                    iy_start <= iy_start + s_ext;
                end
            end else begin
                ox       <= ox + 16'd1;
                ix_start <= ix_start + s_ext;
            end
        end
    end

endmodule

`default_nettype wire
